/* logic/iq_pkg.sv */
`default_nettype none

package iq_pkg;

    // instruction and address widths
    localparam int INST_W = 32;
    localparam int PC_W = 64;

    // one cache line of instructions
    localparam int LINE_INSTS = 16;
    localparam int OFFSET_W = 4;

    // entry buffer, pointers carry an extra wrap bit
    localparam int DEPTH = 32;
    localparam int PTR_W = 5;
    localparam int CNT_W = 6;

    // issue lanes towards decode
    localparam int ISSUE_W = 2;

    typedef struct packed {
        logic                         valid;
        logic [PC_W-1:0]              pc;
        logic [LINE_INSTS*INST_W-1:0] data;
    } fetch_line_t;

    typedef struct packed {
        logic [PC_W-1:0]   pc;
        logic [INST_W-1:0] inst;
    } iq_entry_t;

    typedef struct packed {
        logic      valid;
        iq_entry_t entry;
    } iq_lane_t;

    // slot 0 holds the instruction at the fetch PC
    typedef struct packed {
        logic                        valid;
        logic [CNT_W-1:0]            cnt;
        iq_entry_t [0:LINE_INSTS-1]  slots;
    } aligned_line_t;

endpackage

`default_nettype wire

/* logic/iq_line_aligner.sv */
`timescale 1ns/1ps
`default_nettype none

module iq_line_aligner
    import iq_pkg::*;
(
    input  wire fetch_line_t line_i,
    output aligned_line_t    aligned_o
);

    logic [OFFSET_W-1:0] offset;

    // word offset of the fetch PC inside the 64-byte line
    assign offset = line_i.pc[OFFSET_W+1:2];

    always_comb begin
        int src;

        aligned_o.valid = line_i.valid;
        aligned_o.cnt   = CNT_W'(LINE_INSTS) - CNT_W'(offset);

        for (int j = 0; j < LINE_INSTS; j++) begin
            src = int'(offset) + j;
            if (src < LINE_INSTS) begin
                aligned_o.slots[j].pc   = line_i.pc + PC_W'(4 * j);
                aligned_o.slots[j].inst = line_i.data[src*INST_W +: INST_W];
            end else begin
                // past the end of the line
                aligned_o.slots[j] = '0;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/iq_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module iq_buffer
    import iq_pkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire aligned_line_t           aligned_i,
    input  wire logic                    flush_i,
    input  wire logic [1:0]              pop_cnt_i,
    output iq_lane_t [ISSUE_W-1:0]       head_o,
    output logic                         full_o
);

    iq_entry_t mem [DEPTH];

    logic [PTR_W:0]   wptr;
    logic [PTR_W:0]   rptr;
    logic [CNT_W-1:0] occ;
    logic [CNT_W-1:0] free_cnt;
    logic [1:0]       head_cnt;
    logic             wr_en;

    // occupancy straight from the wrapped pointers
    assign occ      = wptr - rptr;
    assign free_cnt = CNT_W'(DEPTH) - occ;

    // room for a whole line or nothing
    assign full_o = free_cnt < CNT_W'(LINE_INSTS);

    assign wr_en = aligned_i.valid && !full_o && !flush_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wptr <= '0;
            rptr <= '0;
        end else if (flush_i) begin
            wptr <= '0;
            rptr <= '0;
        end else begin
            if (wr_en) begin
                wptr <= wptr + aligned_i.cnt;
            end
            rptr <= rptr + {{(PTR_W-1){1'b0}}, pop_cnt_i};
        end
    end

    // only the live part of the aligned line is stored
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int j = 0; j < LINE_INSTS; j++) begin
                if (CNT_W'(j) < aligned_i.cnt) begin
                    mem[wptr[PTR_W-1:0] + PTR_W'(j)] <= aligned_i.slots[j];
                end
            end
        end
    end

    // two oldest entries, lane 0 first
    always_comb begin
        for (int l = 0; l < ISSUE_W; l++) begin
            head_o[l].valid = occ > CNT_W'(l);
            head_o[l].entry = mem[rptr[PTR_W-1:0] + PTR_W'(l)];
        end
    end

    assign head_cnt = (occ >= CNT_W'(ISSUE_W)) ? 2'(ISSUE_W) : occ[1:0];

    // issue stage may only take what the head offers
    a_pop_within_head: assert property (
        @(posedge clk) disable iff (!rst_n)
        pop_cnt_i <= head_cnt
    ) else $error("pop count %0d above valid head lanes %0d", pop_cnt_i, head_cnt);

    a_occ_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        occ <= CNT_W'(DEPTH)
    ) else $error("occupancy %0d above depth", occ);

    // a write never overruns the read pointer
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_en |-> free_cnt >= aligned_i.cnt
    ) else $error("line of %0d written with %0d free", aligned_i.cnt, free_cnt);

endmodule

`default_nettype wire

/* logic/iq_issue_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module iq_issue_stage
    import iq_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire iq_lane_t [ISSUE_W-1:0] head_i,
    input  wire logic                   stall_i,
    input  wire logic                   flush_i,
    output logic [1:0]                  pop_cnt_o,
    output iq_lane_t [ISSUE_W-1:0]      lanes_o
);

    logic      [ISSUE_W-1:0] lane_vld_q;
    iq_entry_t [ISSUE_W-1:0] lane_entry_q;
    logic                    load;
    logic      [1:0]         head_cnt;

    assign load = !stall_i && !flush_i;

    always_comb begin
        head_cnt = '0;
        for (int l = 0; l < ISSUE_W; l++) begin
            head_cnt = head_cnt + {1'b0, head_i[l].valid};
        end
    end

    // pop exactly what gets loaded
    assign pop_cnt_o = load ? head_cnt : 2'd0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lane_vld_q <= '0;
        end else if (flush_i) begin
            lane_vld_q <= '0;
        end else if (!stall_i) begin
            for (int l = 0; l < ISSUE_W; l++) begin
                lane_vld_q[l] <= head_i[l].valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            for (int l = 0; l < ISSUE_W; l++) begin
                lane_entry_q[l] <= head_i[l].entry;
            end
        end
    end

    always_comb begin
        for (int l = 0; l < ISSUE_W; l++) begin
            lanes_o[l].valid = lane_vld_q[l];
            lanes_o[l].entry = lane_entry_q[l];
        end
    end

    // odd leftover goes out alone in lane 0
    a_lane_order: assert property (
        @(posedge clk) disable iff (!rst_n)
        lanes_o[1].valid |-> lanes_o[0].valid
    ) else $error("lane 1 valid without lane 0");

endmodule

`default_nettype wire

/* logic/inst_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_queue
    import iq_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst_n,
    // from the instruction cache
    input  wire fetch_line_t       line_i,
    output logic                   full_o,
    // backend control
    input  wire logic              stall_i,
    input  wire logic              flush_i,
    // to decode
    output iq_lane_t [ISSUE_W-1:0] lanes_o
);

    aligned_line_t          aligned;
    iq_lane_t [ISSUE_W-1:0] head;
    logic     [1:0]         pop_cnt;

    iq_line_aligner u_aligner (
        .line_i    (line_i),
        .aligned_o (aligned)
    );

    iq_buffer u_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .aligned_i (aligned),
        .flush_i   (flush_i),
        .pop_cnt_i (pop_cnt),
        .head_o    (head),
        .full_o    (full_o)
    );

    iq_issue_stage u_issue (
        .clk       (clk),
        .rst_n     (rst_n),
        .head_i    (head),
        .stall_i   (stall_i),
        .flush_i   (flush_i),
        .pop_cnt_o (pop_cnt),
        .lanes_o   (lanes_o)
    );

endmodule

`default_nettype wire

/* verif/iq_model.svh */
`ifndef IQ_MODEL_SVH
`define IQ_MODEL_SVH

// expected contents of the queue, oldest first
iq_entry_t model_q [$];

// expected issue lanes after the latest edge
iq_lane_t exp_lanes [ISSUE_W];

int unsigned lines_accepted;
int unsigned lines_blocked;
int unsigned insts_loaded;

task automatic model_reset();
    model_q.delete();
    foreach (exp_lanes[l]) begin
        exp_lanes[l] = '0;
    end
    lines_accepted = 0;
    lines_blocked  = 0;
    insts_loaded   = 0;
endtask

// fewer than a whole line of free entries
function automatic logic model_full();
    return (DEPTH - model_q.size()) < LINE_INSTS;
endfunction

// one rising edge, with the inputs that were presented before it
task automatic model_step(input fetch_line_t line, input logic stall, input logic flush);
    int        k;
    logic      full;
    iq_entry_t e;

    full = model_full();
    if (flush) begin
        model_q.delete();
        foreach (exp_lanes[l]) begin
            exp_lanes[l] = '0;
        end
    end else begin
        // lanes take the oldest entries, lane 0 first
        if (!stall) begin
            for (int l = 0; l < ISSUE_W; l++) begin
                if (model_q.size() > 0) begin
                    exp_lanes[l].valid = 1'b1;
                    exp_lanes[l].entry = model_q.pop_front();
                    insts_loaded++;
                end else begin
                    exp_lanes[l].valid = 1'b0;
                end
            end
        end
        if (line.valid && full) begin
            lines_blocked++;
        end else if (line.valid) begin
            // skip the words before the fetch PC
            k = int'(line.pc[5:2]);
            for (int j = 0; j < LINE_INSTS - k; j++) begin
                e.pc   = line.pc + 64'(4 * j);
                e.inst = line.data[(k + j) * INST_W +: INST_W];
                model_q.push_back(e);
            end
            lines_accepted++;
        end
    end
endtask

// entry bits only matter on a valid lane
task automatic check_lane(input string name, input iq_lane_t exp, input iq_lane_t act);
    if (exp.valid !== act.valid || (exp.valid && exp.entry !== act.entry)) begin
        $display("ERROR %s expected %h actual %h", name, exp, act);
        report_fail($sformatf("%s does not match the expected lane", name));
    end
endtask

task automatic check_full(input string name, input logic exp, input logic act);
    if (exp !== act) begin
        $display("ERROR %s expected %h actual %h", name, exp, act);
        report_fail($sformatf("%s does not match the occupancy rule", name));
    end
endtask

`endif

/* verif/tb_inst_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_inst_queue
    import iq_pkg::*;
();

    localparam int unsigned SEED           = 32'h96cfd321;
    localparam int          RESET_CYCLES   = 5;
    localparam int          RUN_CYCLES     = 3000;
    localparam int          TIMEOUT_CYCLES = RUN_CYCLES + RUN_CYCLES / 3;

    logic                   clk;
    logic                   rst_n;
    fetch_line_t            line_i;
    logic                   full_o;
    logic                   stall_i;
    logic                   flush_i;
    iq_lane_t [ISSUE_W-1:0] lanes_o;

    iq_lane_t [ISSUE_W-1:0] prev_lanes;
    int                     cycle_cnt;

    `include "iq_model.svh"

    inst_queue dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .line_i  (line_i),
        .full_o  (full_o),
        .stall_i (stall_i),
        .flush_i (flush_i),
        .lanes_o (lanes_o)
    );

    always #2 clk = ~clk;

    task automatic report_fail(input string reason);
        $display(">>> FAIL");
        $fatal(1, "%s", reason);
    endtask

    // run can never outlast the test length by much
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            report_fail($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    task automatic drive_random();
        fetch_line_t line;

        line.valid = $urandom_range(99) < 40;
        line.pc    = {$urandom, $urandom};
        for (int w = 0; w < LINE_INSTS; w++) begin
            line.data[w*INST_W +: INST_W] = $urandom;
        end
        line_i  = line;
        stall_i = $urandom_range(99) < 30;
        flush_i = $urandom_range(99) < 2;
    endtask

    task automatic drive_idle();
        line_i  = '0;
        stall_i = 1'b0;
        flush_i = 1'b0;
    endtask

    // one edge, then compare once everything has settled
    task automatic run_cycle();
        logic                   stall_s;
        logic                   flush_s;
        iq_lane_t [ISSUE_W-1:0] lanes_s;

        @(posedge clk);
        stall_s = stall_i;
        flush_s = flush_i;
        model_step(line_i, stall_s, flush_s);
        #1;
        lanes_s = lanes_o;
        if (flush_s) begin
            for (int l = 0; l < ISSUE_W; l++) begin
                check_lane($sformatf("lanes_o[%0d] after flush", l), '0, lanes_s[l]);
            end
            check_full("full_o after flush", 1'b0, full_o);
        end else begin
            if (stall_s) begin
                for (int l = 0; l < ISSUE_W; l++) begin
                    check_lane($sformatf("lanes_o[%0d] under stall", l), prev_lanes[l],
                               lanes_s[l]);
                end
            end else begin
                for (int l = 0; l < ISSUE_W; l++) begin
                    check_lane($sformatf("lanes_o[%0d]", l), exp_lanes[l], lanes_s[l]);
                end
            end
            check_full("full_o", model_full(), full_o);
        end
        prev_lanes = lanes_s;
    endtask

    initial begin
        void'($urandom(SEED));
        clk       = 1'b0;
        rst_n     = 1'b0;
        cycle_cnt = 0;
        drive_idle();
        model_reset();

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // queue comes up empty
        for (int l = 0; l < ISSUE_W; l++) begin
            check_lane($sformatf("lanes_o[%0d] after reset", l), '0, lanes_o[l]);
        end
        check_full("full_o after reset", 1'b0, full_o);
        prev_lanes = lanes_o;

        repeat (RUN_CYCLES) begin
            drive_random();
            run_cycle();
        end

        // let whatever is left drain out
        drive_idle();
        while (model_q.size() > 0 || exp_lanes[0].valid) begin
            run_cycle();
        end

        $display("lines accepted %0d, blocked %0d, instructions %0d",
                 lines_accepted, lines_blocked, insts_loaded);
        if (lines_accepted > 0 && insts_loaded > 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            report_fail("no line was accepted or no instruction was issued");
        end
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+verif
logic/iq_pkg.sv
logic/iq_line_aligner.sv
logic/iq_buffer.sv
logic/iq_issue_stage.sv
logic/inst_queue.sv
verif/tb_inst_queue.sv

/* Makefile */
# Verilator build of the instruction queue testbench

BIN  := obj_dir/Vtb_inst_queue
SRCS := $(shell grep -v '^+' sim.f) verif/iq_model.svh

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): sim.f $(SRCS)
	verilator --binary --timing --assert -j 0 \
		--top-module tb_inst_queue \
		-Mdir obj_dir \
		-f sim.f

# a failing run ends in $$fatal, which gives a nonzero exit status
run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir
